//--- hw/mem_stage_pkg.sv
/*
 * RV32I memory stage shared definitions.
 * Widths, load/store size codes and the structs that carry
 * the EX/MEM entry, the memory request, the store record and WB result.
 */
package mem_stage_pkg;

    // ============================================================
    // Widths
    // ============================================================
    localparam int XLEN      = 32;              // Data and address width
    localparam int REG_AW    = 5;               // Register index width
    localparam int NUM_LANES = 4;               // Byte lanes per word

    // ============================================================
    // funct3 codes
    // ============================================================
    localparam logic [2:0] F3_LB  = 3'b000;     // Byte, signed
    localparam logic [2:0] F3_LH  = 3'b001;     // Half, signed
    localparam logic [2:0] F3_LW  = 3'b010;     // Word
    localparam logic [2:0] F3_LBU = 3'b100;     // Byte, unsigned
    localparam logic [2:0] F3_LHU = 3'b101;     // Half, unsigned

    // Access size, low two bits of funct3 for loads and stores
    localparam logic [1:0] SZ_BYTE = 2'b00;
    localparam logic [1:0] SZ_HALF = 2'b01;
    localparam logic [1:0] SZ_WORD = 2'b10;

    // ============================================================
    // Stage structs
    // ============================================================
    typedef struct packed {
        logic              valid;               // Slot holds an instruction
        logic              mem_read;            // Load
        logic              mem_write;           // Store
        logic              reg_write;           // Writes rd
        logic              mem_to_reg;          // Result comes from memory
        logic [2:0]        funct3;              // Size and sign
        logic [REG_AW-1:0] rd;                  // Destination register
        logic [XLEN-1:0]   alu_result;          // Byte address or ALU value
        logic [XLEN-1:0]   rs2_data;            // Store data, unshifted
    } ex_mem_t;

    typedef struct packed {
        logic                 ren;              // Read strobe
        logic                 wen;              // Write strobe
        logic [XLEN-1:0]      addr;             // Word aligned
        logic [XLEN-1:0]      wdata;            // Lane shifted
        logic [NUM_LANES-1:0] mask;             // Byte enables
    } dmem_req_t;

    typedef struct packed {
        logic              valid;
        logic              is_load;             // Valid untrapped load
        logic              is_store;            // Valid untrapped store
        logic              mem_to_reg;
        logic              reg_write;
        logic [REG_AW-1:0] rd;
        logic [2:0]        funct3;
        logic [1:0]        byte_off;            // Byte within the word
        logic [XLEN-1:2]   word_addr;           // Address without byte bits
        logic [XLEN-1:0]   alu_result;
    } mem_word_t;

    typedef struct packed {
        logic                 valid;            // Previous entry was a store
        logic [XLEN-1:2]      word_addr;
        logic [XLEN-1:0]      data;             // Lane shifted
        logic [NUM_LANES-1:0] mask;
    } store_rec_t;

    typedef struct packed {
        logic              valid;
        logic              reg_write;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;                // Load value or ALU result
    } wb_t;

endpackage

//--- hw/mem_access.sv
/*
 * EX/MEM register and memory request generation.
 * Splits the byte address, builds the store lane mask and data,
 * checks alignment and strobes the word memory for good accesses.
 */
`timescale 1ns/10ps

module mem_access
    import mem_stage_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  ex_mem_t    i_ex,
    input  logic       i_stall,
    output dmem_req_t  o_dmem,
    output mem_word_t  o_cur,                   // Current access
    output store_rec_t o_store,                 // Current store, for the record
    output logic       o_trap_misaligned
);

    // ============================================================
    // EX/MEM register
    // ============================================================
    ex_mem_t ex_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ex_q.valid      <= 1'b0;            // Control only
            ex_q.mem_read   <= 1'b0;
            ex_q.mem_write  <= 1'b0;
            ex_q.reg_write  <= 1'b0;
            ex_q.mem_to_reg <= 1'b0;
        end else if (!i_stall) begin
            ex_q <= i_ex;                       // Hold while stalled
        end
    end

    // ============================================================
    // Address split and store format
    // ============================================================
    logic [1:0]           byte_off;
    logic [1:0]           acc_size;
    logic [XLEN-1:2]      word_addr;
    logic [NUM_LANES-1:0] lane_mask;
    logic [XLEN-1:0]      store_data;
    logic                 misaligned;
    logic                 is_access;
    logic                 trap;
    logic                 do_load;
    logic                 do_store;

    assign byte_off  = ex_q.alu_result[1:0];
    assign acc_size  = ex_q.funct3[1:0];        // Same code for loads and stores
    assign word_addr = ex_q.alu_result[XLEN-1:2];

    always_comb begin
        case (acc_size)
            SZ_BYTE: lane_mask = NUM_LANES'(4'b0001) << byte_off;  // One lane
            SZ_HALF: lane_mask = NUM_LANES'(4'b0011) << byte_off;  // Two lanes
            default: lane_mask = '1;                               // Full word
        endcase
    end

    assign store_data = ex_q.rs2_data << {byte_off, 3'b000};       // Into its lanes

    // ============================================================
    // Alignment trap
    // ============================================================
    always_comb begin
        case (acc_size)
            SZ_HALF: misaligned = byte_off[0];          // Odd half
            SZ_WORD: misaligned = (byte_off != 2'b00);  // Word off a 4-byte line
            default: misaligned = 1'b0;                 // Bytes always fit
        endcase
    end

    assign is_access = ex_q.valid && (ex_q.mem_read || ex_q.mem_write);
    assign trap      = is_access && misaligned;
    assign do_load   = ex_q.valid && ex_q.mem_read  && !misaligned;  // No access on trap
    assign do_store  = ex_q.valid && ex_q.mem_write && !misaligned;

    assign o_trap_misaligned = trap;

    // ============================================================
    // Memory request
    // ============================================================
    assign o_dmem.ren   = do_load;
    assign o_dmem.wen   = do_store;
    assign o_dmem.addr  = {word_addr, 2'b00};
    assign o_dmem.wdata = store_data;
    assign o_dmem.mask  = do_store ? lane_mask : '0;  // Quiet unless writing

    // Current access for forwarding and load
    assign o_cur.valid      = ex_q.valid;
    assign o_cur.is_load    = do_load;
    assign o_cur.is_store   = do_store;
    assign o_cur.mem_to_reg = ex_q.mem_to_reg;
    assign o_cur.reg_write  = ex_q.reg_write;
    assign o_cur.rd         = ex_q.rd;
    assign o_cur.funct3     = ex_q.funct3;
    assign o_cur.byte_off   = byte_off;
    assign o_cur.word_addr  = word_addr;
    assign o_cur.alu_result = ex_q.alu_result;

    // Store as the record will see it
    assign o_store.valid     = do_store;
    assign o_store.word_addr = word_addr;
    assign o_store.data      = store_data;
    assign o_store.mask      = lane_mask;

    // ============================================================
    // Checks
    // ============================================================
    a_no_rd_wr: assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_dmem.ren && o_dmem.wen));            // One access per entry

    a_stall_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        i_stall |=> $stable(o_dmem));            // Held entry repeats its request

endmodule

//--- hw/store_forward.sv
/*
 * Store-to-load forwarding.
 * Keeps the store that left EX/MEM last and merges its bytes into
 * the memory word when the next access loads the same word.
 */
`timescale 1ns/10ps

module store_forward
    import mem_stage_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_stall,
    input  mem_word_t       i_cur,              // Current access
    input  store_rec_t      i_store,            // Current store, if any
    input  logic [XLEN-1:0] i_dmem_rdata,       // Raw memory word
    output logic [XLEN-1:0] o_rdata             // Word after forwarding
);

    // ============================================================
    // Last store record
    // ============================================================
    store_rec_t rec_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rec_q.valid <= 1'b0;
        end else if (!i_stall) begin
            rec_q <= i_store;                   // Entry leaving EX/MEM
        end
    end

    // ============================================================
    // Merge
    // ============================================================
    logic            hit;
    logic [XLEN-1:0] merged;

    // Write still posted in memory, so the word is stale there
    assign hit = rec_q.valid && i_cur.is_load && (rec_q.word_addr == i_cur.word_addr);

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            merged[8*i +: 8] = rec_q.mask[i] ? rec_q.data[8*i +: 8]    // New byte
                                             : i_dmem_rdata[8*i +: 8]; // Old byte
        end
    end

    assign o_rdata = hit ? merged : i_dmem_rdata;

    // ============================================================
    // Checks
    // ============================================================
    // A recorded store always came from a request with lanes set
    a_rec_mask: assert property (@(posedge i_clk) disable iff (i_rst)
        rec_q.valid |-> (rec_q.mask != '0));

endmodule

//--- hw/load_align.sv
/*
 * Load extraction and writeback select.
 * Picks the byte or half lane named by the offset, extends it
 * by funct3 and chooses between load data and the ALU result.
 */
`timescale 1ns/10ps

module load_align
    import mem_stage_pkg::*;
(
    input  mem_word_t       i_cur,              // Current access
    input  logic [XLEN-1:0] i_rdata,            // Memory word, forwarded
    output wb_t             o_wb
);

    // ============================================================
    // Lane select
    // ============================================================
    logic [7:0]      byte_lane;
    logic [15:0]     half_lane;
    logic [XLEN-1:0] load_val;

    always_comb begin
        case (i_cur.byte_off)
            2'b00:   byte_lane = i_rdata[7:0];
            2'b01:   byte_lane = i_rdata[15:8];
            2'b10:   byte_lane = i_rdata[23:16];
            default: byte_lane = i_rdata[31:24];
        endcase
    end

    // Aligned halves only, odd offsets trap upstream
    assign half_lane = i_cur.byte_off[1] ? i_rdata[31:16] : i_rdata[15:0];

    // ============================================================
    // Extension
    // ============================================================
    always_comb begin
        case (i_cur.funct3)
            F3_LB: begin
                load_val = {{(XLEN-8){byte_lane[7]}}, byte_lane};      // Sign
            end
            F3_LH: begin
                load_val = {{(XLEN-16){half_lane[15]}}, half_lane};    // Sign
            end
            F3_LW: begin
                load_val = i_rdata;                                    // Whole word
            end
            F3_LBU: begin
                load_val = {{(XLEN-8){1'b0}}, byte_lane};              // Zero
            end
            F3_LHU: begin
                load_val = {{(XLEN-16){1'b0}}, half_lane};             // Zero
            end
            default: begin
                load_val = i_rdata;             // Not a load code
            end
        endcase
    end

    // ============================================================
    // Writeback
    // ============================================================
    assign o_wb.valid     = i_cur.valid;
    assign o_wb.reg_write = i_cur.reg_write;
    assign o_wb.rd        = i_cur.rd;
    assign o_wb.data      = i_cur.mem_to_reg ? load_val : i_cur.alu_result;

endmodule

//--- hw/mem_stage_top.sv
/*
 * RV32I memory-access stage.
 * Registers the EX entry, drives a plain word memory port,
 * forwards the last store into a following load and builds the WB result.
 */
`timescale 1ns/10ps

module mem_stage_top
    import mem_stage_pkg::*;
(
    // ============================================================
    // Clock and reset
    // ============================================================
    input  logic            i_clk,
    input  logic            i_rst,              // Sync, active high

    // ============================================================
    // From EX
    // ============================================================
    input  ex_mem_t         i_ex,               // Entry captured at the edge
    input  logic            i_stall,            // Hold the stage

    // ============================================================
    // Data memory port
    // ============================================================
    output dmem_req_t       o_dmem,             // Request, valid this cycle
    input  logic [XLEN-1:0] i_dmem_rdata,       // Comb. read data for o_dmem.addr

    // ============================================================
    // To WB
    // ============================================================
    output wb_t             o_wb,
    output logic            o_trap_misaligned   // Misaligned load/store
);

    mem_word_t       cur;                       // Entry now in EX/MEM
    store_rec_t      cur_store;                 // Its store bytes, if any
    logic [XLEN-1:0] fwd_rdata;                 // Memory word after forwarding

    // Register, address split, store format, trap
    mem_access u_mem_access (
        .i_clk             (i_clk),
        .i_rst             (i_rst),
        .i_ex              (i_ex),
        .i_stall           (i_stall),
        .o_dmem            (o_dmem),
        .o_cur             (cur),
        .o_store           (cur_store),
        .o_trap_misaligned (o_trap_misaligned)
    );

    // Posted write cover for a load right after a store
    store_forward u_store_forward (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_stall      (i_stall),
        .i_cur        (cur),
        .i_store      (cur_store),
        .i_dmem_rdata (i_dmem_rdata),
        .o_rdata      (fwd_rdata)
    );

    // Lane pick, extension, result mux
    load_align u_load_align (
        .i_cur   (cur),
        .i_rdata (fwd_rdata),
        .o_wb    (o_wb)
    );

endmodule

//--- tb/tb_dmem_model.sv
/*
 * Word memory model for the memory stage testbench.
 * Reads are combinational, writes are posted and commit one clock later.
 */
`timescale 1ns/10ps

module tb_dmem_model
    import mem_stage_pkg::*;
(
    input  logic            i_clk,
    input  dmem_req_t       i_req,              // Request from the stage
    output logic [XLEN-1:0] o_rdata             // Word at i_req.addr
);

    localparam int AW    = 6;                   // Word index bits
    localparam int DEPTH = 1 << AW;

    logic [XLEN-1:0] mem [DEPTH];
    dmem_req_t       post_q;                    // Write waiting to commit
    logic [XLEN-1:0] commit_word;               // Old word with new lanes

    // Every byte carries the word index
    function automatic logic [XLEN-1:0] fill_word(input int idx);
        logic [7:0] b;
        b = 8'(idx);
        return {8'hC0 + b, 8'h80 + b, 8'h40 + b, b};
    endfunction

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = fill_word(i);
        end
        post_q = '0;                            // Nothing posted yet
    end

    assign o_rdata = mem[i_req.addr[AW+1:2]];   // Same-cycle read

    // ============================================================
    // Posted write, committed at the edge after it was taken
    // ============================================================
    always @(posedge i_clk) begin
        if (post_q.wen === 1'b1) begin
            commit_word = mem[post_q.addr[AW+1:2]];
            for (int k = 0; k < NUM_LANES; k++) begin
                if (post_q.mask[k]) begin
                    commit_word[8*k +: 8] = post_q.wdata[8*k +: 8];  // Masked lane
                end
            end
            mem[post_q.addr[AW+1:2]] <= commit_word;
        end
        post_q <= i_req;                        // Take this cycle's request
    end

endmodule

//--- tb/tb_mem_stage.sv
/*
 * Testbench for the RV32I memory stage.
 * Replays a trace of loads, stores and ALU entries with stalls and
 * checks writeback, trap, read and write strobes in every cycle.
 */
`timescale 1ns/10ps

module tb_mem_stage
    import mem_stage_pkg::*;
();

    typedef struct packed {
        logic              valid;
        logic              chk_data;            // Off for trapped entries
        logic [XLEN-1:0]   data;
        logic              trap;
        logic              wen;
        logic              ren;
        logic              reg_write;
        logic [REG_AW-1:0] rd;
    } expect_t;

    logic            i_clk;
    logic            i_rst;
    logic            i_stall;
    ex_mem_t         i_ex;
    dmem_req_t       dmem_req;
    logic [XLEN-1:0] dmem_rdata;
    wb_t             wb;
    logic            trap_misaligned;

    expect_t         cur_exp;                   // Entry now in EX/MEM
    expect_t         op_exp;
    expect_t         idle_exp;
    ex_mem_t         op_ex;
    ex_mem_t         idle_ex;
    integer          seed;
    integer          fd;
    integer          got;
    integer          n_ops;
    integer          t_stall;
    string           line;
    logic [31:0]     t_valid, t_read, t_write, t_regw, t_m2r, t_f3, t_rd;
    logic [31:0]     t_addr, t_rs2, t_data, t_trap, t_wen;

    mem_stage_top DUT (
        .i_clk             (i_clk),
        .i_rst             (i_rst),
        .i_ex              (i_ex),
        .i_stall           (i_stall),
        .i_dmem_rdata      (dmem_rdata),
        .o_dmem            (dmem_req),
        .o_wb              (wb),
        .o_trap_misaligned (trap_misaligned)
    );

    tb_dmem_model u_dmem (
        .i_clk   (i_clk),
        .i_req   (dmem_req),
        .o_rdata (dmem_rdata)
    );

    initial i_clk = 1'b0;
    always #4 i_clk = ~i_clk;                   // 8 ns period

    // ============================================================
    // Reporting and per-cycle helpers
    // ============================================================
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic fail_value(input string name, input logic [XLEN-1:0] exp_v,
                              input logic [XLEN-1:0] act_v);
        stop_run($sformatf("error: time %0t signal %s expected %h actual %h",
                           $time, name, exp_v, act_v));
    endtask

    task automatic check_outputs(input expect_t e);
        integer n;
        n = 0;
        while (e.valid && wb.valid !== 1'b1 && n < 20) begin
            @(negedge i_clk);
            n = n + 1;
        end
        if (e.valid && wb.valid !== 1'b1) begin
            stop_run("Timeout: o_wb.valid never rose within 20 cycles");
        end else begin
            assert (wb.valid === e.valid)
                else fail_value("o_wb.valid", XLEN'(e.valid), XLEN'(wb.valid));
            assert (dmem_req.ren === e.ren)
                else fail_value("o_dmem.ren", XLEN'(e.ren), XLEN'(dmem_req.ren));
            assert (dmem_req.wen === e.wen)
                else fail_value("o_dmem.wen", XLEN'(e.wen), XLEN'(dmem_req.wen));
            assert (trap_misaligned === e.trap)
                else fail_value("o_trap_misaligned", XLEN'(e.trap), XLEN'(trap_misaligned));
            if (e.valid) begin
                assert (wb.rd === e.rd)
                    else fail_value("o_wb.rd", XLEN'(e.rd), XLEN'(wb.rd));
                assert (wb.reg_write === e.reg_write)
                    else fail_value("o_wb.reg_write", XLEN'(e.reg_write),
                                    XLEN'(wb.reg_write));
                if (e.chk_data) begin
                    assert (wb.data === e.data) else fail_value("o_wb.data", e.data, wb.data);
                end
            end
        end
    endtask

    // Drive, check mid-cycle, then track what the edge captured
    task automatic run_cycle(input ex_mem_t ex, input logic stall, input expect_t nxt);
        i_ex    = ex;
        i_stall = stall;
        @(negedge i_clk);
        check_outputs(cur_exp);
        @(posedge i_clk);
        if (!stall) cur_exp = nxt;              // Held while stalled
        #1;
    endtask

    // Non-memory ALU entry, result is its own alu_result
    task automatic make_idle(output ex_mem_t ex, output expect_t e);
        ex            = '0;
        ex.valid      = 1'b1;
        ex.reg_write  = 1'b1;
        ex.funct3     = 3'($random(seed));
        ex.rd         = REG_AW'($random(seed));
        ex.alu_result = $random(seed);
        ex.rs2_data   = $random(seed);
        e             = '0;
        e.valid       = 1'b1;
        e.chk_data    = 1'b1;
        e.data        = ex.alu_result;
        e.reg_write   = 1'b1;
        e.rd          = ex.rd;
    endtask

    // ============================================================
    // Reset, trace replay, drain
    // ============================================================
    initial begin
        seed         = 6;
        n_ops        = 0;
        cur_exp      = '0;
        i_rst        = 1'b1;
        i_stall      = 1'b0;
        i_ex         = '0;
        i_ex.valid   = 1'b1;                    // Store waiting during reset
        i_ex.mem_write = 1'b1;
        i_ex.funct3  = F3_LW;
        fd = $fopen("tb/mem_stage_trace.txt", "r");
        if (fd == 0) stop_run("Could not open tb/mem_stage_trace.txt");
        @(posedge i_clk);
        @(negedge i_clk);
        check_outputs(cur_exp);                 // Quiet in reset
        @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            if (got > 0 && line.len() > 1 && line[0] != "#") begin
                got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %d %h %h %h",
                              t_valid, t_read, t_write, t_regw, t_m2r, t_f3, t_rd,
                              t_addr, t_rs2, t_stall, t_data, t_trap, t_wen);
                if (got != 13) stop_run("Malformed trace line");
                op_ex            = '0;
                op_ex.valid      = t_valid[0];
                op_ex.mem_read   = t_read[0];
                op_ex.mem_write  = t_write[0];
                op_ex.reg_write  = t_regw[0];
                op_ex.mem_to_reg = t_m2r[0];
                op_ex.funct3     = t_f3[2:0];
                op_ex.rd         = t_rd[REG_AW-1:0];
                op_ex.alu_result = t_addr;
                op_ex.rs2_data   = t_rs2;
                op_exp.valid     = t_valid[0];
                op_exp.chk_data  = !t_trap[0];  // Trapped result is flushed later
                op_exp.data      = t_data;
                op_exp.trap      = t_trap[0];
                op_exp.wen       = t_wen[0];
                op_exp.ren       = t_valid[0] && t_read[0] && !t_trap[0];
                op_exp.reg_write = t_regw[0];   // Passes straight through
                op_exp.rd        = t_rd[REG_AW-1:0];
                run_cycle(op_ex, 1'b0, op_exp);
                repeat (t_stall) begin
                    make_idle(idle_ex, idle_exp);
                    run_cycle(idle_ex, 1'b1, idle_exp);  // Must not be taken
                end
                n_ops = n_ops + 1;
            end
        end
        $fclose(fd);
        repeat (3) begin
            make_idle(idle_ex, idle_exp);
            run_cycle(idle_ex, 1'b0, idle_exp);
        end
        if (n_ops == 0) begin
            stop_run("Trace held no operations");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

//--- tb/mem_stage_trace.txt
# valid mem_read mem_write reg_write mem_to_reg funct3 rd alu_result rs2_data stall
# then expected wb_data trap wen; all hex except stall, which is decimal
1 0 0 1 0 0 01 12345678 00000000 0 12345678 0 0
1 0 1 0 0 2 00 00000020 deadbeef 0 00000020 0 1
1 0 0 1 0 0 02 0000abcd 00000000 0 0000abcd 0 0
1 1 0 1 1 2 03 00000020 00000000 0 deadbeef 0 0
1 0 1 0 0 0 00 00000021 123456a5 0 00000021 0 1
1 1 0 1 1 2 04 00000020 00000000 0 deada5ef 0 0
1 1 0 1 1 0 05 00000021 00000000 0 ffffffa5 0 0
1 1 0 1 1 4 06 00000023 00000000 0 000000de 0 0
1 0 1 0 0 1 00 00000022 00008001 0 00000022 0 1
1 1 0 1 1 1 07 00000022 00000000 0 ffff8001 0 0
1 1 0 1 1 5 08 00000020 00000000 0 0000a5ef 0 0
1 1 0 1 1 1 09 00000020 00000000 0 ffffa5ef 0 0
1 0 1 0 0 0 00 00000030 0000007f 2 00000030 0 1
1 1 0 1 1 2 0a 00000030 00000000 3 cc8c4c7f 0 0
1 1 0 1 1 0 0b 00000031 00000000 0 0000004c 0 0
1 1 0 1 1 0 0c 00000033 00000000 0 ffffffcc 0 0
1 0 1 0 0 0 00 00000032 00000011 0 00000032 0 1
1 0 1 0 0 0 00 00000033 00000022 0 00000033 0 1
1 1 0 1 1 2 0d 00000030 00000000 0 22114c7f 0 0
1 0 1 0 0 2 00 00000042 baadf00d 0 00000000 1 0
1 1 0 1 1 1 0e 00000041 00000000 0 00000000 1 0
1 1 0 1 1 2 0f 00000040 00000000 0 d0905010 0 0
1 0 0 1 0 0 1f cafef00d 00000000 2 cafef00d 0 0
1 0 1 0 0 1 00 00000024 ffff1234 0 00000024 0 1
1 1 0 1 1 5 10 00000026 00000000 0 0000c989 0 0
1 1 0 1 1 2 11 00000024 00000000 0 c9891234 0 0

//--- mem_stage.f
hw/mem_stage_pkg.sv
hw/mem_access.sv
hw/store_forward.sv
hw/load_align.sv
hw/mem_stage_top.sv
tb/tb_dmem_model.sv
tb/tb_mem_stage.sv
